/* common/bram_pkg.sv */
`default_nettype none

package bram_pkg;

    // bank geometry
    localparam int NUM_BANKS   = 4;
    localparam int BANK_DEPTH  = 512;
    localparam int WORD_ADDR_W = 9;
    localparam int BANK_SEL_W  = 2;

    // data path
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int BYTE_W = DATA_W / STRB_W;

    // apb address layout: [15:13] zero, [12:11] bank, [10:2] word, [1:0] zero
    localparam int PADDR_W  = 16;
    localparam int WORD_LSB = 2;
    localparam int BANK_LSB = WORD_LSB + WORD_ADDR_W;
    localparam int HIGH_LSB = BANK_LSB + BANK_SEL_W;

    // power-up contents of every bank, one byte pattern per word
    localparam int PRELOAD_LEN = 10;

    localparam logic [DATA_W-1:0] preload_pattern [PRELOAD_LEN] = '{
        32'h0101_0101,
        32'haaaa_aaaa,
        32'h5555_5555,
        32'hffff_ffff,
        32'hf0f0_f0f0,
        32'h0f0f_0f0f,
        32'hcccc_cccc,
        32'h3333_3333,
        32'h0202_0202,
        32'h0404_0404
    };

    // front end handshake states
    typedef enum logic [1:0] {
        st_idle,
        st_read_wait,
        st_read_done
    } apb_state_e;

endpackage

`default_nettype wire

/* rtl/bram_apb_front.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_apb_front (
    input  logic                              rdclk,
    input  logic                              reset,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [bram_pkg::PADDR_W-1:0]      paddr,
    input  logic [bram_pkg::DATA_W-1:0]       pwdata,
    input  logic [bram_pkg::STRB_W-1:0]       pstrb,
    output logic                              pready,
    output logic                              pslverr,
    output logic [bram_pkg::NUM_BANKS-1:0]    bank_wren,
    output logic [bram_pkg::NUM_BANKS-1:0]    bank_rden,
    output logic [bram_pkg::WORD_ADDR_W-1:0]  word_addr,
    output logic [bram_pkg::DATA_W-1:0]       wdata,
    output logic [bram_pkg::STRB_W-1:0]       wstrb,
    output logic                              rd_launch,
    output logic [bram_pkg::BANK_SEL_W-1:0]   rd_bank
);
    import bram_pkg::*;

    apb_state_e state;
    apb_state_e state_next;

    logic                  access;
    logic                  addr_legal;
    logic                  wr_hit;
    logic [BANK_SEL_W-1:0] bank_sel;
    logic [NUM_BANKS-1:0]  bank_onehot;

    // address decode
    assign access      = psel && penable;
    assign addr_legal  = (paddr[WORD_LSB-1:0] == '0) && (paddr[PADDR_W-1:HIGH_LSB] == '0);
    assign bank_sel    = paddr[HIGH_LSB-1:BANK_LSB];
    assign bank_onehot = NUM_BANKS'(1) << bank_sel;

    // shared bank bus
    assign word_addr = paddr[BANK_LSB-1:WORD_LSB];
    assign wdata     = pwdata;
    assign wstrb     = pstrb;

    // writes and errors finish in the first access cycle from idle
    assign wr_hit    = access && (state == st_idle) && pwrite && addr_legal;
    assign rd_launch = access && (state == st_read_wait);
    assign rd_bank   = bank_sel;

    assign bank_wren = wr_hit ? bank_onehot : '0;
    assign bank_rden = rd_launch ? bank_onehot : '0;

    assign pready  = (state == st_read_done) || (access && (state == st_idle));
    assign pslverr = access && (state == st_idle) && !addr_legal;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // legal read seen in setup, next access cycle fires the bank
                if (psel && !penable && !pwrite && addr_legal) begin
                    state_next = st_read_wait;
                end
            end
            st_read_wait: begin
                if (access) begin
                    state_next = st_read_done;
                end else if (!psel) begin
                    state_next = st_idle;
                end
            end
            st_read_done: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge rdclk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // read_done raises pready from state alone, master must still be in access
    a_ready_in_access: assert property (
        @(posedge rdclk) disable iff (reset) pready |-> (psel && penable)
    );

endmodule

`default_nettype wire

/* bram_bank/bram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_bank (
    input  logic                              rdclk,
    input  logic                              wren,
    input  logic                              rden,
    input  logic [bram_pkg::WORD_ADDR_W-1:0]  word_addr,
    input  logic [bram_pkg::DATA_W-1:0]       wdata,
    input  logic [bram_pkg::STRB_W-1:0]       wstrb,
    output logic [bram_pkg::DATA_W-1:0]       rdata
);
    import bram_pkg::*;

    logic [DATA_W-1:0] mem [BANK_DEPTH];

    // power-up image: test pattern at the bottom, zero above
    initial begin
        for (int i = 0; i < BANK_DEPTH; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < PRELOAD_LEN; i++) begin
            mem[i] = preload_pattern[i];
        end
    end

    // byte-lane write
    always_ff @(posedge rdclk) begin
        if (wren) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[word_addr][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // registered read, holds last word when idle
    always_ff @(posedge rdclk) begin
        if (rden) begin
            rdata <= mem[word_addr];
        end
    end

    // front end never drives both strobes of one bank in a cycle
    a_no_rw_overlap: assert property (
        @(posedge rdclk) !(wren && rden)
    );

endmodule

`default_nettype wire

/* rtl/bank_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_read_mux (
    input  logic                              rdclk,
    input  logic                              reset,
    input  logic                              rd_launch,
    input  logic [bram_pkg::BANK_SEL_W-1:0]   rd_bank,
    input  logic [bram_pkg::DATA_W-1:0]       bank_rdata [bram_pkg::NUM_BANKS],
    output logic [bram_pkg::DATA_W-1:0]       prdata
);
    import bram_pkg::*;

    logic [BANK_SEL_W-1:0] rd_bank_q;
    logic                  data_valid;

    // bank number captured on the same edge the bank registers its word
    always_ff @(posedge rdclk) begin
        if (reset) begin
            rd_bank_q  <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= rd_launch;
            if (rd_launch) begin
                rd_bank_q <= rd_bank;
            end
        end
    end

    // only the read completion cycle shows bank data, zero otherwise
    always_comb begin
        if (data_valid) begin
            prdata = bank_rdata[rd_bank_q];
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/bram_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_test_top (
    input  logic                            rdclk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [bram_pkg::PADDR_W-1:0]    paddr,
    input  logic [bram_pkg::DATA_W-1:0]     pwdata,
    input  logic [bram_pkg::STRB_W-1:0]     pstrb,
    output logic [bram_pkg::DATA_W-1:0]     prdata,
    output logic                            pready,
    output logic                            pslverr
);
    import bram_pkg::*;

    logic [NUM_BANKS-1:0]   bank_wren;
    logic [NUM_BANKS-1:0]   bank_rden;
    logic [WORD_ADDR_W-1:0] word_addr;
    logic [DATA_W-1:0]      wdata;
    logic [STRB_W-1:0]      wstrb;
    logic                   rd_launch;
    logic [BANK_SEL_W-1:0]  rd_bank;
    logic [DATA_W-1:0]      bank_rdata [NUM_BANKS];

    bram_apb_front bram_apb_front_inst (
        .rdclk     (rdclk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .pslverr   (pslverr),
        .bank_wren (bank_wren),
        .bank_rden (bank_rden),
        .word_addr (word_addr),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .rd_launch (rd_launch),
        .rd_bank   (rd_bank)
    );

    // banks share address, data and strobes, one-hot enables pick the target
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        bram_bank bram_bank_inst (
            .rdclk     (rdclk),
            .wren      (bank_wren[g]),
            .rden      (bank_rden[g]),
            .word_addr (word_addr),
            .wdata     (wdata),
            .wstrb     (wstrb),
            .rdata     (bank_rdata[g])
        );
    end

    bank_read_mux bank_read_mux_inst (
        .rdclk      (rdclk),
        .reset      (reset),
        .rd_launch  (rd_launch),
        .rd_bank    (rd_bank),
        .bank_rdata (bank_rdata),
        .prdata     (prdata)
    );

endmodule

`default_nettype wire

/* bench/tb_bram_test.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bram_test;
    import bram_pkg::*;

    localparam int MAX_WAIT = 20;

    logic               rdclk;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    logic [DATA_W-1:0]  pwdata;
    logic [STRB_W-1:0]  pstrb;
    logic [DATA_W-1:0]  prdata;
    logic               pready;
    logic               pslverr;

    int num_vectors;

    bram_test_top bram_test_top_inst (
        .rdclk   (rdclk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        rdclk = 1'b0;
        forever begin
            #5 rdclk = ~rdclk;
        end
    end

    // one apb transfer, returns what the slave showed in its completing cycle
    task automatic apb_transfer(
        input  logic               is_write,
        input  logic [PADDR_W-1:0] addr,
        input  logic [STRB_W-1:0]  strb,
        input  logic [DATA_W-1:0]  data,
        output logic [DATA_W-1:0]  rdata,
        output logic               err,
        output int                 waits
    );
        int cycles;
        @(posedge rdclk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(posedge rdclk);
        #1;
        penable = 1'b1;
        // outputs are sampled mid-cycle where they have settled
        @(negedge rdclk);
        cycles = 0;
        while (!pready && cycles < MAX_WAIT) begin
            @(negedge rdclk);
            cycles++;
        end
        if (!pready) begin
            $display("pready never rose within %0d cycles at address %h", MAX_WAIT, addr);
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            rdata = prdata;
            err   = pslverr;
            waits = cycles;
            @(posedge rdclk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    // compare one completed transfer with its line of the data file
    task automatic check_response(
        input logic               is_write,
        input logic [PADDR_W-1:0] addr,
        input logic [DATA_W-1:0]  exp_rdata,
        input logic [DATA_W-1:0]  got_rdata,
        input logic               exp_err,
        input logic               got_err,
        input int                 waits
    );
        assert (got_err == exp_err) else begin
            $display("mismatch pslverr at %h: expected %h, got %h", addr, exp_err, got_err);
            $display("ERRORS FOUND");
            $fatal(1);
        end
        if (!is_write) begin
            assert (got_rdata == exp_rdata) else begin
                $display("mismatch prdata at %h: expected %h, got %h", addr, exp_rdata, got_rdata);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
        // writes and errors end in the first access cycle, reads in the second
        if (is_write || exp_err) begin
            assert (waits == 0) else begin
                $display("access at %h did not complete in its first access cycle", addr);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end else begin
            assert (waits == 1) else begin
                $display("read at %h did not take exactly two access cycles", addr);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
    endtask

    initial begin
        int                 fd;
        int                 count;
        int                 waits;
        string              line;
        logic [3:0]         op;
        logic [PADDR_W-1:0] addr;
        logic [STRB_W-1:0]  strb;
        logic [DATA_W-1:0]  wdata;
        logic [DATA_W-1:0]  exp_rdata;
        logic               exp_err;
        logic [DATA_W-1:0]  got_rdata;
        logic               got_err;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pstrb       = '0;
        reset       = 1'b1;
        num_vectors = 0;
        repeat (4) @(posedge rdclk);
        #1;
        reset = 1'b0;

        fd = $fopen("bench/bram_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/bram_testdata.txt");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
                count = $sscanf(line, "%h %h %h %h %h %h",
                                op, addr, strb, wdata, exp_rdata, exp_err);
                if (count != 6 || op > 4'h1) begin
                    $display("malformed line in data file: %s", line);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
                apb_transfer(op[0], addr, strb, wdata, got_rdata, got_err, waits);
                check_response(op[0], addr, exp_rdata, got_rdata, exp_err, got_err, waits);
                num_vectors++;
            end
        end
        $fclose(fd);

        if (num_vectors == 0) begin
            $display("data file held no vectors");
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/bram_testdata.txt */
# op (1 write, 0 read), paddr, pstrb, pwdata, expected prdata, expected pslverr; all hex
# paddr bits 12:11 pick the bank, bits 10:2 the word
0 0000 0 00000000 01010101 0
0 0004 0 00000000 aaaaaaaa 0
0 0008 0 00000000 55555555 0
0 000c 0 00000000 ffffffff 0
0 0010 0 00000000 f0f0f0f0 0
0 0014 0 00000000 0f0f0f0f 0
0 0018 0 00000000 cccccccc 0
0 001c 0 00000000 33333333 0
0 0020 0 00000000 02020202 0
0 0024 0 00000000 04040404 0
0 0028 0 00000000 00000000 0
0 0824 0 00000000 04040404 0
0 0828 0 00000000 00000000 0
0 1024 0 00000000 04040404 0
0 1028 0 00000000 00000000 0
0 1824 0 00000000 04040404 0
0 1828 0 00000000 00000000 0
1 0050 f 12345678 00000000 0
0 0050 0 00000000 12345678 0
1 0814 5 aabbccdd 00000000 0
0 0814 0 00000000 0fbb0fdd 0
1 0078 f 11110000 00000000 0
1 0878 f 22220001 00000000 0
1 1078 f 33330002 00000000 0
1 1878 f 44440003 00000000 0
0 0078 0 00000000 11110000 0
0 0878 0 00000000 22220001 0
0 1078 0 00000000 33330002 0
0 1878 0 00000000 44440003 0
1 0052 f deadbeef 00000000 1
1 2050 f deadbeef 00000000 1
0 0050 0 00000000 12345678 0
0 0051 0 00000000 00000000 1

/* files.f */
common/bram_pkg.sv
rtl/bram_apb_front.sv
bram_bank/bram_bank.sv
rtl/bank_read_mux.sv
rtl/bram_test_top.sv
bench/tb_bram_test.sv

/* run_sim.sh */
#!/bin/sh
# builds the bench with Verilator and runs it; the exit status is the simulator's
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_bram_test \
    --Mdir obj_dir \
    -o sim_bram_test

./obj_dir/sim_bram_test
